// ==== common/sprite_config.svh ====
// Build-time constants for the sprite display engine
// Screen and sprite geometry, reset motion state and update rate
// Include wherever one of these values is needed; the packages derive widths from them

`ifndef SPRITE_CONFIG_SVH
`define SPRITE_CONFIG_SVH

// Visible raster, one pixel per clock
`define SCREEN_W 128
`define SCREEN_H 96

// Sprite box in pixels
`define SPRITE_W 8
`define SPRITE_H 6

// Top-left corner after reset
`define INIT_X 104
`define INIT_Y 78

// Pixels per update, signed; multiples that land exactly on the edges
`define INIT_VX 8
`define INIT_VY 6

// Frames between two movement updates, at least 1
`define FRAMES_PER_UPDATE 2

`endif

// ==== common/spriteGeomPkg.sv ====
// Types for the sprite's own geometry
// Coordinates name the top-left corner of the sprite box
// Velocities are signed steps applied once per movement update

package spriteGeomPkg;

    `include "sprite_config.svh"

    // Wide enough for the larger screen axis
    localparam int coordW = $clog2(`SCREEN_W);

    // Unsigned corner coordinate, x or y
    typedef logic [coordW-1:0] coordT;

    // One extra bit so a full-range step keeps its sign
    typedef logic signed [coordW:0] velT;

    // Corner position as carried over the position link
    typedef struct packed {
        coordT x;   // Column of left edge
        coordT y;   // Row of top edge
    } spritePosT;

    // Motion state, one component per axis
    typedef struct packed {
        velT x;
        velT y;
    } spriteVelT;

endpackage

// ==== common/displayPkg.sv ====
// Types for the raster side of the engine
// Beam counters from the scan timer and the per-pixel coverage result

package displayPkg;

    `include "sprite_config.svh"

    localparam int beamXW = $clog2(`SCREEN_W);
    localparam int beamYW = $clog2(`SCREEN_H);

    typedef logic [beamXW-1:0] beamXT;  // Beam column
    typedef logic [beamYW-1:0] beamYT;  // Beam row

    // Registered rasterizer result, one per beam pixel
    typedef struct packed {
        beamXT x;           // Column this result belongs to
        beamYT y;           // Row this result belongs to
        logic  covered;     // Sprite covers the pixel
    } pixelT;

endpackage

// ==== common/posLinkIf.sv ====
// Four-phase req/ack link that carries a new sprite position
// Source holds pos stable with req high until ack; sink acks after latching pos
// Source drops req, sink drops ack, and only then may req rise again

`timescale 1ns/10ps

interface posLinkIf;

    logic                    req;   // New position offered
    logic                    ack;   // Position taken by the sink
    spriteGeomPkg::spritePosT pos;  // Offered corner, stable while req

    // Movement side
    modport source (
        output req,
        output pos,
        input  ack
    );

    // Rasterizer side
    modport sink (
        input  req,
        input  pos,
        output ack
    );

endinterface

// ==== verilog/scanTimer.sv ====
// Raster beam generator for the sprite engine
// Walks the beam over the screen one pixel per clock, x first
// frameStart marks the clock where the beam sits at (0,0)
// updateStrobe rides on every FRAMES_PER_UPDATE-th frame start

`timescale 1ns/10ps

`include "sprite_config.svh"

module scanTimer (
    input  logic              clk,
    input  logic              reset,
    output displayPkg::beamXT beamX,
    output displayPkg::beamYT beamY,
    output logic              frameStart,
    output logic              updateStrobe
);
    import displayPkg::*;

    localparam int frameCntW = $clog2(`FRAMES_PER_UPDATE + 1);
    localparam int lastX = `SCREEN_W - 1;
    localparam int lastY = `SCREEN_H - 1;

    logic [frameCntW-1:0] frameCnt;     // Completed frames in this update period
    logic                 lineEnd;      // Beam on last column
    logic                 lastPixel;    // Beam on final pixel of the frame

    assign lineEnd    = (beamX == beamXT'(lastX));
    assign lastPixel  = lineEnd && (beamY == beamYT'(lastY));
    assign frameStart = (beamX == '0) && (beamY == '0);    // Decoded from counters

    // Beam counters
    always_ff @(posedge clk) begin
        if (reset) begin
            beamX <= '0;
            beamY <= '0;
        end else if (lineEnd) begin
            beamX <= '0;                // Wrap column
            if (lastPixel) begin
                beamY <= '0;            // Wrap to top
            end else begin
                beamY <= beamY + 1'b1;
            end
        end else begin
            beamX <= beamX + 1'b1;
        end
    end

    // Strobe is set on the last pixel so it lands with the next frame start
    always_ff @(posedge clk) begin
        if (reset) begin
            frameCnt     <= '0;
            updateStrobe <= 1'b0;
        end else if (lastPixel) begin
            if (frameCnt == frameCntW'(`FRAMES_PER_UPDATE - 1)) begin
                frameCnt     <= '0;     // Period complete
                updateStrobe <= 1'b1;
            end else begin
                frameCnt     <= frameCnt + 1'b1;
                updateStrobe <= 1'b0;
            end
        end else begin
            updateStrobe <= 1'b0;       // Single-clock pulse
        end
    end

    // Registered strobe must line up with the decoded frame start
    strobeOnFrameStart: assert property (@(posedge clk) disable iff (reset)
        updateStrobe |-> frameStart);

endmodule

// ==== movement/movementController.sv ====
// Moves the sprite's top-left corner by a signed velocity on each update
// Bounces off the screen edges and only moves while moveEnable is high
// Each new position is offered to the rasterizer over the source side of
// the position link; strobes during a busy link wait as one pending update

`timescale 1ns/10ps

`include "sprite_config.svh"

module movementController (
    input  logic      clk,
    input  logic      reset,
    input  logic      moveEnable,
    input  logic      updateStrobe,
    posLinkIf.source  link
);
    import spriteGeomPkg::*;

    typedef enum logic [1:0] {
        linkIdle,       // No position outstanding
        linkReq,        // req high, waiting for ack
        linkRelease     // req dropped, waiting for ack to fall
    } linkStateT;

    linkStateT state;
    spritePosT curPos;      // Current corner, also the link payload
    spriteVelT curVel;      // Current velocity
    spriteVelT nextVel;     // Velocity after bounce check
    spritePosT nextPos;     // Corner after one step
    velT       stepX;
    velT       stepY;
    logic      pending;     // Update waiting for an idle link
    logic      serve;       // Update taken this clock

    assign serve = pending && (state == linkIdle);

    // Bounce is decided from the position before the step
    always_comb begin
        nextVel = curVel;
        if ((int'(curPos.x) + `SPRITE_W >= `SCREEN_W) || (curPos.x == '0)) begin
            nextVel.x = -curVel.x;      // Left or right edge
        end
        if ((int'(curPos.y) + `SPRITE_H >= `SCREEN_H) || (curPos.y == '0)) begin
            nextVel.y = -curVel.y;      // Top or bottom edge
        end
        stepX     = velT'({1'b0, curPos.x}) + nextVel.x;
        stepY     = velT'({1'b0, curPos.y}) + nextVel.y;
        nextPos.x = coordT'(stepX);     // Drop sign bit
        nextPos.y = coordT'(stepY);
    end

    // Strobes merge into a single pending update
    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= (pending && !serve) || updateStrobe;
        end
    end

    // Motion state
    always_ff @(posedge clk) begin
        if (reset) begin
            curPos.x <= coordT'(`INIT_X);
            curPos.y <= coordT'(`INIT_Y);
            curVel.x <= velT'(`INIT_VX);
            curVel.y <= velT'(`INIT_VY);
        end else if (serve && moveEnable) begin
            curPos <= nextPos;
            curVel <= nextVel;
        end
    end

    // Source side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= linkIdle;
        end else begin
            case (state)
                linkIdle: begin
                    if (serve && moveEnable) begin
                        state <= linkReq;       // req rises after the new corner is held
                    end
                end
                linkReq: begin
                    if (link.ack) begin
                        state <= linkRelease;   // Drop req
                    end
                end
                linkRelease: begin
                    if (!link.ack) begin
                        state <= linkIdle;
                    end
                end
                default: state <= linkIdle;
            endcase
        end
    end

    assign link.req = (state == linkReq);
    assign link.pos = curPos;

    // Sink sees one corner for the whole request
    posStableDuringReq: assert property (@(posedge clk) disable iff (reset)
        link.req && $past(link.req) |-> $stable(link.pos));

    // Previous handshake must be fully closed first
    noReqWhileAck: assert property (@(posedge clk) disable iff (reset)
        $rose(link.req) |-> !link.ack);

endmodule

// ==== render/spriteRasterizer.sv ====
// Sink side of the position link plus per-pixel coverage test
// A new corner is taken only at a frame start, so a frame shows one position
// pixel is registered and lags the beam by one clock

`timescale 1ns/10ps

`include "sprite_config.svh"

module spriteRasterizer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     frameStart,
    input  displayPkg::beamXT        beamX,
    input  displayPkg::beamYT        beamY,
    posLinkIf.sink                   link,
    output displayPkg::pixelT        pixel,
    output logic                     posStrobe,
    output spriteGeomPkg::spritePosT shownPos
);
    import displayPkg::*;
    import spriteGeomPkg::*;

    spritePosT drawPos;     // Corner used for the current beam pixel
    logic      latchNow;    // Take the offered corner this clock
    logic      inX;
    logic      inY;

    assign latchNow  = frameStart && link.req && !link.ack;
    assign posStrobe = latchNow;                            // Same clock as frameStart
    assign drawPos   = latchNow ? link.pos : shownPos;      // New frame uses new corner

    // Far edge excluded, int math avoids wrap at the screen border
    assign inX = (int'(beamX) >= int'(drawPos.x)) && (int'(beamX) < int'(drawPos.x) + `SPRITE_W);
    assign inY = (int'(beamY) >= int'(drawPos.y)) && (int'(beamY) < int'(drawPos.y) + `SPRITE_H);

    // Shown corner and ack
    always_ff @(posedge clk) begin
        if (reset) begin
            shownPos.x <= coordT'(`INIT_X);
            shownPos.y <= coordT'(`INIT_Y);
            link.ack   <= 1'b0;
        end else if (latchNow) begin
            shownPos <= link.pos;
            link.ack <= 1'b1;           // Corner held, acknowledge
        end else if (link.ack && !link.req) begin
            link.ack <= 1'b0;           // Close the handshake
        end
    end

    // Pixel result, tagged with the beam position it belongs to
    always_ff @(posedge clk) begin
        pixel.x       <= beamX;
        pixel.y       <= beamY;
        pixel.covered <= inX && inY;
    end

endmodule

// ==== verilog/spriteEngine.sv ====
// Top level of the single-sprite display engine
// Scan timer feeds the movement controller, which hands positions to the
// rasterizer over the req/ack link; results leave on plain ports

`timescale 1ns/10ps

module spriteEngine (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 moveEnable,
    output spriteGeomPkg::coordT xPos,
    output spriteGeomPkg::coordT yPos,
    output logic                 posStrobe,
    output logic                 frameStart,
    output displayPkg::beamXT    pixX,
    output displayPkg::beamYT    pixY,
    output logic                 pixelOn
);
    import displayPkg::*;
    import spriteGeomPkg::*;

    beamXT     beamX;
    beamYT     beamY;
    logic      updateStrobe;
    spritePosT shownPos;
    pixelT     pixel;

    posLinkIf posLink ();

    scanTimer timer0 (
        .clk          (clk),
        .reset        (reset),
        .beamX        (beamX),
        .beamY        (beamY),
        .frameStart   (frameStart),
        .updateStrobe (updateStrobe)
    );

    movementController move0 (
        .clk          (clk),
        .reset        (reset),
        .moveEnable   (moveEnable),
        .updateStrobe (updateStrobe),
        .link         (posLink.source)
    );

    spriteRasterizer raster0 (
        .clk        (clk),
        .reset      (reset),
        .frameStart (frameStart),
        .beamX      (beamX),
        .beamY      (beamY),
        .link       (posLink.sink),
        .pixel      (pixel),
        .posStrobe  (posStrobe),
        .shownPos   (shownPos)
    );

    assign xPos    = shownPos.x;        // Displayed corner
    assign yPos    = shownPos.y;
    assign pixX    = pixel.x;           // One clock behind the beam
    assign pixY    = pixel.y;
    assign pixelOn = pixel.covered;

endmodule

// ==== tb/spriteEngineTb.sv ====
// Testbench for the single-sprite display engine
// Reads one line per update period from the golden file with moveEnable and the
// corner expected on screen after that period
// Checks each update slot, the shown corner and randomly sampled pixels

`timescale 1ns/10ps

`include "sprite_config.svh"

module spriteEngineTb;
    import spriteGeomPkg::*;
    import displayPkg::*;

    localparam int frameClocks   = `SCREEN_W * `SCREEN_H;
    localparam int timeoutClocks = 3 * frameClocks;     // Three frames per wait

    logic      clk;
    logic      reset;
    logic      moveEnable;
    coordT     xPos;
    coordT     yPos;
    logic      posStrobe;
    logic      frameStart;
    beamXT     pixX;
    beamYT     pixY;
    logic      pixelOn;

    spritePosT expPos;          // Corner that should be on screen
    spritePosT lastShown;       // Monitor copy from previous clock
    logic      lastStrobe;
    int        beamIdx;         // Reference beam pixel within the frame
    int        pixIdx;          // Reference pixel the output belongs to
    int        posErrors;
    int        pixErrors;
    int        strobeErrors;
    int        otherErrors;

    spriteEngine dut0 (
        .clk        (clk),
        .reset      (reset),
        .moveEnable (moveEnable),
        .xPos       (xPos),
        .yPos       (yPos),
        .posStrobe  (posStrobe),
        .frameStart (frameStart),
        .pixX       (pixX),
        .pixY       (pixY),
        .pixelOn    (pixelOn)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // Reference beam that advances one pixel per clock from (0,0)
    always @(posedge clk) begin
        pixIdx <= beamIdx;                          // Output lags the beam by one clock
        if (reset) begin
            beamIdx <= 0;
        end else begin
            beamIdx <= (beamIdx + 1) % frameClocks;
        end
    end

    task automatic checkPos(input spritePosT got, input spritePosT exp, input string what);
        if (got !== exp) begin
            posErrors++;
            $display("** Error at %0t: %s position (%0d,%0d), expected (%0d,%0d)",
                     $time, what, got.x, got.y, exp.x, exp.y);
        end
    endtask

    task automatic checkPixel(input pixelT got, input pixelT exp);
        if (got !== exp) begin
            pixErrors++;
            $display("** Error at %0t: pixel (%0d,%0d) covered %0b, expected (%0d,%0d) covered %0b",
                     $time, got.x, got.y, got.covered, exp.x, exp.y, exp.covered);
        end
    endtask

    // Coverage rule with the far edge excluded
    function automatic pixelT expectedPixel(input beamXT x, input beamYT y, input spritePosT pos);
        int    dx;
        int    dy;
        pixelT p;
        dx        = int'(x) - int'(pos.x);
        dy        = int'(y) - int'(pos.y);
        p.x       = x;
        p.y       = y;
        p.covered = (dx >= 0) && (dx < `SPRITE_W) && (dy >= 0) && (dy < `SPRITE_H);
        return p;
    endfunction

    // Dense sampling around the sprite box and sparse sampling elsewhere
    task automatic samplePixel;
        pixelT got;
        pixelT exp;
        int    dx;
        int    dy;
        logic  nearBox;
        got.x       = pixX;
        got.y       = pixY;
        got.covered = pixelOn;
        dx          = int'(pixX) - int'(expPos.x);
        dy          = int'(pixY) - int'(expPos.y);
        nearBox     = (dx >= -2) && (dx <= `SPRITE_W + 1) && (dy >= -2) && (dy <= `SPRITE_H + 1);
        if (nearBox ? ($urandom % 2 == 0) : ($urandom % 1024 == 0)) begin
            exp   = expectedPixel(pixX, pixY, expPos);
            exp.x = beamXT'(pixIdx % `SCREEN_W);        // Coordinates from the reference beam
            exp.y = beamYT'(pixIdx / `SCREEN_W);
            checkPixel(got, exp);
        end
    endtask

    // Counts frame starts up to the update slot with a timeout per frame
    task automatic waitSlot(input int starts, output logic ok);
        int seen;
        int clocks;
        seen   = 0;
        clocks = 0;
        ok     = 1'b1;
        while (seen < starts && ok) begin
            @(negedge clk);
            samplePixel();
            clocks++;
            if (frameStart) begin
                seen++;
                clocks = 0;
            end else if (clocks >= timeoutClocks) begin
                ok = 1'b0;
            end
        end
    endtask

    // Strobe only with frame start and corner changes only after a strobe
    always @(negedge clk) begin
        if (!reset && frameStart !== (beamIdx == 0)) begin
            strobeErrors++;
            $display("** Error at %0t: frameStart %0b, expected %0b",
                     $time, frameStart, beamIdx == 0);
        end
        if (!reset && posStrobe && !frameStart) begin
            strobeErrors++;
            $display("** Error at %0t: posStrobe high outside a frame start", $time);
        end
        if (!reset && spritePosT'({xPos, yPos}) != lastShown && !lastStrobe) begin
            strobeErrors++;
            $display("** Error at %0t: position changed without posStrobe", $time);
        end
        lastShown  = spritePosT'({xPos, yPos});
        lastStrobe = posStrobe;
    end

    initial begin
        int          fd;
        int          en;
        int          ex;
        int          ey;
        int          lines;
        int          total;
        int unsigned seedDummy;
        logic        enBit;
        logic        ok;
        string       line;
        posErrors    = 0;
        pixErrors    = 0;
        strobeErrors = 0;
        otherErrors  = 0;
        lines        = 0;
        reset        = 1'b1;
        moveEnable   = 1'b0;
        seedDummy    = $urandom(15);
        expPos.x     = coordT'(`INIT_X);
        expPos.y     = coordT'(`INIT_Y);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);                                 // Frame 0 start
        checkPos(spritePosT'({xPos, yPos}), expPos, "reset");
        fd = $fopen("tb/spriteEngine_golden.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open the golden file tb/spriteEngine_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %d %d", en, ex, ey) != 3) begin
                    continue;                           // Comment or blank
                end
                enBit = (en != 0);
                @(posedge clk);
                moveEnable <= enBit;
                // First corner arrives one frame after the first update
                waitSlot((lines == 0) ? `FRAMES_PER_UPDATE + 1 : `FRAMES_PER_UPDATE, ok);
                if (!ok) begin
                    otherErrors++;
                    $display("Timed out: no frame start seen within three frames");
                    break;
                end
                if (posStrobe !== enBit) begin
                    strobeErrors++;
                    $display("** Error at %0t: posStrobe %0b at update slot, expected %0b",
                             $time, posStrobe, enBit);
                end
                expPos.x = coordT'(ex);
                expPos.y = coordT'(ey);
                @(negedge clk);                         // Shown corner registered
                checkPos(spritePosT'({xPos, yPos}), expPos, "shown");
                lines++;
            end
            $fclose(fd);
            if (lines == 0) begin
                otherErrors++;
                $display("The golden file held no update lines");
            end
        end
        total = posErrors + pixErrors + strobeErrors + otherErrors;
        $display("Errors: position %0d, pixel %0d, strobe %0d, other %0d",
                 posErrors, pixErrors, strobeErrors, otherErrors);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb/spriteEngine_golden.txt ====
# Columns: moveEnable for the update period, expected xPos, expected yPos after it
# Start (104,78) with velocity (+8,+6); lines starting with # are skipped
1 112 84
1 120 90
1 112 84
0 112 84
0 112 84
0 112 84
1 104 78
1 96 72
1 88 66
1 80 60
1 72 54
1 64 48
1 56 42
1 48 36
1 40 30
1 32 24
1 24 18
1 16 12
1 8 6
1 0 0
1 8 6
1 16 12

// ==== filelist.f ====
+incdir+common
common/spriteGeomPkg.sv
common/displayPkg.sv
common/posLinkIf.sv
verilog/scanTimer.sv
movement/movementController.sv
render/spriteRasterizer.sv
verilog/spriteEngine.sv
tb/spriteEngineTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the sprite engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f filelist.f \
    --top-module spriteEngineTb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/VspriteEngineTb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1
